// ==== design/ccu_monitor_config.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCU burst monitor configuration
// widths and depths shared by the monitor package and its modules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CCU_MONITOR_CONFIG_SVH
`define CCU_MONITOR_CONFIG_SVH

// four transaction IDs
`define CCU_ID_WIDTH 2
// burst length field, beats minus one
`define CCU_LEN_WIDTH 4
// entries per expected-burst FIFO
`define CCU_FIFO_DEPTH 4
// atomic op code and its read-response bit
`define CCU_ATOP_WIDTH 6
`define CCU_ATOP_R_RESP 5
`define CCU_CNT_WIDTH 8

`endif

// ==== design/ccu_monitor_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCU burst monitor package
// channel, report and status types of the AXI burst-protocol monitor
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ccu_monitor_config.svh"

package ccu_monitor_pkg;

  typedef logic [`CCU_ID_WIDTH-1:0]   id_t;
  typedef logic [`CCU_LEN_WIDTH-1:0]  len_t;
  typedef logic [`CCU_ATOP_WIDTH-1:0] atop_t;
  typedef logic [`CCU_CNT_WIDTH-1:0]  cnt_t;
  // one bit wider than len so a full burst plus overrun still fits
  typedef logic [`CCU_LEN_WIDTH:0]    beat_cnt_t;

  typedef enum logic {
    VERDICT_OK,
    VERDICT_LAST_MISMATCH
  } verdict_e;

  // one expected burst, from AW, AR or the injector
  typedef struct packed {
    id_t   id;
    len_t  len;
    atop_t atop;
  } burst_req_t;

  // W beats carry id zero
  typedef struct packed {
    id_t  id;
    logic last;
  } beat_t;

  typedef struct packed {
    id_t       id;
    len_t      len;
    beat_cnt_t beats;
    atop_t     atop;
    verdict_e  verdict;
  } burst_report_t;

  typedef struct packed {
    logic orphan_w;
    logic orphan_r;
    logic fifo_drop;
    logic inject_drop;
  } mon_status_t;

endpackage

// ==== design/burst_len_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected burst FIFO
// in-order queue of burst requests, drops pushes when full
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ccu_monitor_config.svh"

module burst_len_fifo
  import ccu_monitor_pkg::*;
#(
  parameter int unsigned DEPTH = `CCU_FIFO_DEPTH
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  burst_req_t req_i,
  input  logic       pop_i,
  output burst_req_t head_o,
  output logic       empty_o,
  output logic       drop_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  burst_req_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;
  // high only while the push strobe meets a full queue
  assign drop_o  = push_i && full;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

// ==== design/atomic_injector.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Atomic read injector
// turns response-bearing atomic AWs into expected read bursts and holds
// one derived request until the read tracker takes it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ccu_monitor_config.svh"

module atomic_injector
  import ccu_monitor_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       aw_fire_i,
  input  burst_req_t aw_i,
  input  logic       inj_accept_i,
  output logic       inj_valid_o,
  output burst_req_t inj_req_o,
  output logic       inject_drop_o
);

  logic       inj_valid_q;
  burst_req_t inj_req_q;
  logic       drop_q;
  logic       is_rresp;
  logic       hold_free;
  len_t       derived_len;

  assign is_rresp  = aw_fire_i && aw_i.atop[`CCU_ATOP_R_RESP];
  // holding register frees up in the cycle its content is accepted
  assign hold_free = !inj_valid_q || inj_accept_i;
  // read data of an atomic is half the write burst above two beats
  assign derived_len = (aw_i.len > len_t'(1)) ? (aw_i.len >> 1) : aw_i.len;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      inj_valid_q <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      if (is_rresp && hold_free) begin
        inj_valid_q <= 1'b1;
      end else if (inj_accept_i) begin
        inj_valid_q <= 1'b0;
      end
      if (is_rresp && !hold_free) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_rresp && hold_free) begin
      inj_req_q <= '{id: aw_i.id, len: derived_len, atop: aw_i.atop};
    end
  end

  assign inj_valid_o   = inj_valid_q;
  assign inj_req_o     = inj_req_q;
  assign inject_drop_o = drop_q;

endmodule

// ==== design/write_tracker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write burst tracker
// matches AW requests in order with W beats, checks the last flag
// position and counts B responses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module write_tracker
  import ccu_monitor_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          aw_fire_i,
  input  burst_req_t    aw_i,
  input  logic          w_fire_i,
  input  beat_t         w_i,
  input  logic          b_fire_i,
  output logic          wr_done_o,
  output burst_report_t wr_report_o,
  output cnt_t          b_count_o,
  output logic          orphan_w_o,
  output logic          fifo_drop_o
);

  burst_req_t    head;
  logic          empty;
  logic          drop;
  logic          w_take;
  logic          w_last;
  beat_cnt_t     beat_cnt_q;
  logic          wr_done_q;
  burst_report_t wr_report_q;
  cnt_t          b_count_q;
  logic          orphan_w_q;
  logic          fifo_drop_q;

  // beats only count against a pending AW
  assign w_take = w_fire_i && !empty;
  assign w_last = w_take && w_i.last;

  burst_len_fifo i_aw_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (aw_fire_i),
    .req_i   (aw_i),
    .pop_i   (w_last),
    .head_o  (head),
    .empty_o (empty),
    .drop_o  (drop)
  );

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      beat_cnt_q  <= '0;
      wr_done_q   <= 1'b0;
      b_count_q   <= '0;
      orphan_w_q  <= 1'b0;
      fifo_drop_q <= 1'b0;
    end else begin
      wr_done_q <= w_last;
      if (w_take) begin
        beat_cnt_q <= w_i.last ? '0 : beat_cnt_q + 1'b1;
      end
      if (b_fire_i) begin
        b_count_q <= b_count_q + 1'b1;
      end
      if (w_fire_i && empty) begin
        orphan_w_q <= 1'b1;
      end
      if (drop) begin
        fifo_drop_q <= 1'b1;
      end
    end
  end

  // last must land on beat index len
  always_ff @(posedge clk_i) begin
    if (w_last) begin
      wr_report_q.id      <= head.id;
      wr_report_q.len     <= head.len;
      wr_report_q.beats   <= beat_cnt_q + 1'b1;
      wr_report_q.atop    <= head.atop;
      wr_report_q.verdict <= (beat_cnt_q == {1'b0, head.len}) ? VERDICT_OK
                                                              : VERDICT_LAST_MISMATCH;
    end
  end

  assign wr_done_o   = wr_done_q;
  assign wr_report_o = wr_report_q;
  assign b_count_o   = b_count_q;
  assign orphan_w_o  = orphan_w_q;
  assign fifo_drop_o = fifo_drop_q;

endmodule

// ==== design/read_tracker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read burst tracker
// keeps one expected-burst FIFO and beat counter per ID, matches R beats
// against the head of their ID and checks the last flag position
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_tracker
  import ccu_monitor_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          ar_fire_i,
  input  burst_req_t    ar_i,
  input  logic          inj_valid_i,
  input  burst_req_t    inj_req_i,
  input  logic          r_fire_i,
  input  beat_t         r_i,
  output logic          inj_accept_o,
  output logic          rd_done_o,
  output burst_report_t rd_report_o,
  output logic          orphan_r_o,
  output logic          fifo_drop_o
);

  localparam int unsigned NUM_IDS = 2 ** $bits(id_t);

  burst_req_t         head [NUM_IDS];
  beat_cnt_t          beat_cnt_q [NUM_IDS];
  logic [NUM_IDS-1:0] empty;
  logic [NUM_IDS-1:0] drop;
  logic               push_en;
  burst_req_t         push_req;
  logic               r_take;
  logic               r_last;
  logic               rd_done_q;
  burst_report_t      rd_report_q;
  logic               orphan_r_q;
  logic               fifo_drop_q;

  // one push per cycle, an AR wins over the injector
  assign inj_accept_o = !ar_fire_i;

  always_comb begin
    push_en  = 1'b0;
    push_req = inj_req_i;
    if (ar_fire_i) begin
      push_en  = 1'b1;
      // plain reads carry no atomic op
      push_req = '{id: ar_i.id, len: ar_i.len, atop: '0};
    end else if (inj_valid_i) begin
      push_en = 1'b1;
    end
  end

  assign r_take = r_fire_i && !empty[r_i.id];
  assign r_last = r_take && r_i.last;

  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_id
    burst_len_fifo i_ar_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (push_en && (push_req.id == id_t'(i))),
      .req_i   (push_req),
      .pop_i   (r_last && (r_i.id == id_t'(i))),
      .head_o  (head[i]),
      .empty_o (empty[i]),
      .drop_o  (drop[i])
    );

    always_ff @(posedge clk_i) begin
      if (rst_ni) begin
        beat_cnt_q[i] <= '0;
      end else if (r_take && (r_i.id == id_t'(i))) begin
        beat_cnt_q[i] <= r_i.last ? '0 : beat_cnt_q[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rd_done_q   <= 1'b0;
      orphan_r_q  <= 1'b0;
      fifo_drop_q <= 1'b0;
    end else begin
      rd_done_q <= r_last;
      if (r_fire_i && empty[r_i.id]) begin
        orphan_r_q <= 1'b1;
      end
      if (|drop) begin
        fifo_drop_q <= 1'b1;
      end
    end
  end

  // report from the head entry of the beat's own ID
  always_ff @(posedge clk_i) begin
    if (r_last) begin
      rd_report_q.id      <= r_i.id;
      rd_report_q.len     <= head[r_i.id].len;
      rd_report_q.beats   <= beat_cnt_q[r_i.id] + 1'b1;
      rd_report_q.atop    <= head[r_i.id].atop;
      rd_report_q.verdict <= (beat_cnt_q[r_i.id] == {1'b0, head[r_i.id].len})
                             ? VERDICT_OK : VERDICT_LAST_MISMATCH;
    end
  end

  assign rd_done_o   = rd_done_q;
  assign rd_report_o = rd_report_q;
  assign orphan_r_o  = orphan_r_q;
  assign fifo_drop_o = fifo_drop_q;

endmodule

// ==== design/ccu_monitor_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCU burst monitor top level
// observes one AXI port, tracks write and read bursts, injects expected
// reads for atomics and collects the sticky status flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ccu_monitor_top
  import ccu_monitor_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  burst_req_t    aw_i,
  input  logic          aw_valid_i,
  input  logic          aw_ready_i,
  input  beat_t         w_i,
  input  logic          w_valid_i,
  input  logic          w_ready_i,
  input  id_t           b_id_i,
  input  logic          b_valid_i,
  input  logic          b_ready_i,
  input  burst_req_t    ar_i,
  input  logic          ar_valid_i,
  input  logic          ar_ready_i,
  input  beat_t         r_i,
  input  logic          r_valid_i,
  input  logic          r_ready_i,
  output logic          wr_done_o,
  output burst_report_t wr_report_o,
  output logic          rd_done_o,
  output burst_report_t rd_report_o,
  output cnt_t          b_count_o,
  output mon_status_t   status_o
);

  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       ar_fire;
  logic       r_fire;
  logic       inj_valid;
  burst_req_t inj_req;
  logic       inj_accept;
  logic       orphan_w;
  logic       orphan_r;
  logic       wr_fifo_drop;
  logic       rd_fifo_drop;
  logic       inject_drop;

  assign aw_fire = aw_valid_i && aw_ready_i;
  assign w_fire  = w_valid_i && w_ready_i;
  // B responses are only counted, any ID is accepted
  assign b_fire  = b_valid_i && b_ready_i;
  assign ar_fire = ar_valid_i && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_i;

  write_tracker i_write_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_fire_i   (aw_fire),
    .aw_i        (aw_i),
    .w_fire_i    (w_fire),
    .w_i         (w_i),
    .b_fire_i    (b_fire),
    .wr_done_o   (wr_done_o),
    .wr_report_o (wr_report_o),
    .b_count_o   (b_count_o),
    .orphan_w_o  (orphan_w),
    .fifo_drop_o (wr_fifo_drop)
  );

  atomic_injector i_atomic_injector (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fire_i     (aw_fire),
    .aw_i          (aw_i),
    .inj_accept_i  (inj_accept),
    .inj_valid_o   (inj_valid),
    .inj_req_o     (inj_req),
    .inject_drop_o (inject_drop)
  );

  read_tracker i_read_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ar_fire_i    (ar_fire),
    .ar_i         (ar_i),
    .inj_valid_i  (inj_valid),
    .inj_req_i    (inj_req),
    .r_fire_i     (r_fire),
    .r_i          (r_i),
    .inj_accept_o (inj_accept),
    .rd_done_o    (rd_done_o),
    .rd_report_o  (rd_report_o),
    .orphan_r_o   (orphan_r),
    .fifo_drop_o  (rd_fifo_drop)
  );

  // flags are already sticky in their source blocks
  assign status_o = '{
    orphan_w:    orphan_w,
    orphan_r:    orphan_r,
    fifo_drop:   wr_fifo_drop | rd_fifo_drop,
    inject_drop: inject_drop
  };

endmodule

// ==== verif/ccu_monitor_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCU burst monitor checker
// matches report strobes, the B count and the status flags against the
// expected records of the trace and prints one line per finished test
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ccu_monitor_checker
  import ccu_monitor_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          wr_done_i,
  input  burst_report_t wr_report_i,
  input  logic          rd_done_i,
  input  burst_report_t rd_report_i,
  input  cnt_t          b_count_i,
  input  mon_status_t   status_i,
  input  logic          exp_push_i,
  input  logic [127:0]  exp_name_i,
  input  logic [63:0]   exp_kind_i,
  input  burst_report_t exp_report_i,
  input  cnt_t          exp_value_i,
  output int            pass_cnt_o,
  output int            fail_cnt_o,
  output int            err_cnt_o,
  output int            pending_o
);

  typedef struct packed {
    logic [127:0]  name;
    logic [63:0]   kind;
    burst_report_t report;
    cnt_t          value;
  } exp_rec_t;

  exp_rec_t exp_q [$];
  exp_rec_t new_rec;
  int       test_err;

  function automatic string fmt_report(burst_report_t rep);
    return $sformatf("id=%0d len=%0d beats=%0d atop=%h %s", rep.id, rep.len, rep.beats,
                     rep.atop, (rep.verdict == VERDICT_OK) ? "ok" : "last_mismatch");
  endfunction

  task automatic note_error();
    err_cnt_o++;
    test_err++;
  endtask

  // reports come back in the order the last beats were seen
  task automatic match_report(input logic [63:0] kind, input burst_report_t act);
    exp_rec_t rec;
    if (exp_q.size() == 0 || exp_q[0].kind != kind) begin
      $display("unexpected %0s report with no matching expected record, %s", kind,
               fmt_report(act));
      note_error();
    end else begin
      rec = exp_q.pop_front();
      if (act !== rec.report) begin
        $display("ERR %0s expected %s actual %s", rec.name, fmt_report(rec.report),
                 fmt_report(act));
        note_error();
      end
    end
  endtask

  task automatic check_value(input exp_rec_t rec, input cnt_t act);
    if (act !== rec.value) begin
      $display("ERR %0s expected %0s %h actual %h", rec.name, rec.kind, rec.value, act);
      note_error();
    end
  endtask

  task automatic finish_test(input logic [127:0] name);
    if (test_err == 0) begin
      $display("test %0s passed", name);
      pass_cnt_o++;
    end else begin
      $display("test %0s failed with %0d errors", name, test_err);
      fail_cnt_o++;
    end
    test_err = 0;
  endtask

  // snapshot and end records are handled once nothing is queued ahead
  task automatic drain_snapshots();
    exp_rec_t rec;
    while (exp_q.size() != 0 && exp_q[0].kind != "wr" && exp_q[0].kind != "rd") begin
      rec = exp_q.pop_front();
      if (rec.kind == "bcount") begin
        check_value(rec, b_count_i);
      end else if (rec.kind == "status") begin
        check_value(rec, cnt_t'(status_i));
      end else if (rec.kind == "end") begin
        finish_test(rec.name);
      end else begin
        $display("expected record of unknown kind %0s in test %0s", rec.kind, rec.name);
        note_error();
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      exp_q.delete();
      test_err   = 0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      err_cnt_o  = 0;
      pending_o  = 0;
    end else begin
      if (exp_push_i) begin
        new_rec.name   = exp_name_i;
        new_rec.kind   = exp_kind_i;
        new_rec.report = exp_report_i;
        new_rec.value  = exp_value_i;
        exp_q.push_back(new_rec);
      end
      if (wr_done_i) begin
        match_report("wr", wr_report_i);
      end
      if (rd_done_i) begin
        match_report("rd", rd_report_i);
      end
      drain_snapshots();
      pending_o = exp_q.size();
    end
  end

endmodule

// ==== verif/tb_ccu_monitor.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCU burst monitor testbench
// replays a cycle trace on the observed AXI port, feeds expected records
// to the checker and bounds the run with a cycle limit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ccu_monitor
  import ccu_monitor_pkg::*;
();

  localparam string TRACE_FILE = "verif/ccu_monitor_trace.txt";

  logic          clk_i;
  logic          rst_ni;
  burst_req_t    aw;
  logic          aw_valid;
  logic          aw_ready;
  beat_t         w;
  logic          w_valid;
  logic          w_ready;
  id_t           b_id;
  logic          b_valid;
  logic          b_ready;
  burst_req_t    ar;
  logic          ar_valid;
  logic          ar_ready;
  beat_t         r;
  logic          r_valid;
  logic          r_ready;
  logic          wr_done;
  burst_report_t wr_report;
  logic          rd_done;
  burst_report_t rd_report;
  cnt_t          b_count;
  mon_status_t   status;

  logic          exp_push;
  logic [127:0]  exp_name;
  logic [63:0]   exp_kind;
  burst_report_t exp_report;
  cnt_t          exp_value;
  int            pass_cnt;
  int            fail_cnt;
  int            err_cnt;
  int            pending;

  int            bad_lines = 0;
  int            cycle_cnt = 0;
  int            cycle_limit = 0;
  logic          open_err = 1'b0;

  ccu_monitor_top i_ccu_monitor_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_i        (aw),
    .aw_valid_i  (aw_valid),
    .aw_ready_i  (aw_ready),
    .w_i         (w),
    .w_valid_i   (w_valid),
    .w_ready_i   (w_ready),
    .b_id_i      (b_id),
    .b_valid_i   (b_valid),
    .b_ready_i   (b_ready),
    .ar_i        (ar),
    .ar_valid_i  (ar_valid),
    .ar_ready_i  (ar_ready),
    .r_i         (r),
    .r_valid_i   (r_valid),
    .r_ready_i   (r_ready),
    .wr_done_o   (wr_done),
    .wr_report_o (wr_report),
    .rd_done_o   (rd_done),
    .rd_report_o (rd_report),
    .b_count_o   (b_count),
    .status_o    (status)
  );

  ccu_monitor_checker i_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_done_i    (wr_done),
    .wr_report_i  (wr_report),
    .rd_done_i    (rd_done),
    .rd_report_i  (rd_report),
    .b_count_i    (b_count),
    .status_i     (status),
    .exp_push_i   (exp_push),
    .exp_name_i   (exp_name),
    .exp_kind_i   (exp_kind),
    .exp_report_i (exp_report),
    .exp_value_i  (exp_value),
    .pass_cnt_o   (pass_cnt),
    .fail_cnt_o   (fail_cnt),
    .err_cnt_o    (err_cnt),
    .pending_o    (pending)
  );

  task automatic drive_idle();
    aw       = '0;
    aw_valid = 1'b0;
    aw_ready = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    w_ready  = 1'b0;
    b_id     = '0;
    b_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    ar_ready = 1'b0;
    r        = '0;
    r_valid  = 1'b0;
    r_ready  = 1'b0;
    exp_push = 1'b0;
  endtask

  // valid/ready columns hold valid in bit 1 and ready in bit 0
  task automatic apply_stim(input int fd);
    int f [14];
    int code;
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                   f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
    if (code != 14) begin
      $display("malformed stimulus line in the trace file");
      bad_lines++;
    end
    drive_idle();
    {aw_valid, aw_ready} = f[0][1:0];
    aw.id   = id_t'(f[1]);
    aw.len  = len_t'(f[2]);
    aw.atop = atop_t'(f[3]);
    {w_valid, w_ready} = f[4][1:0];
    w.last = f[5][0];
    {b_valid, b_ready} = f[6][1:0];
    b_id = id_t'(f[7]);
    {ar_valid, ar_ready} = f[8][1:0];
    ar.id  = id_t'(f[9]);
    ar.len = len_t'(f[10]);
    {r_valid, r_ready} = f[11][1:0];
    r.id   = id_t'(f[12]);
    r.last = f[13][0];
  endtask

  task automatic load_expect(input int fd);
    int v [5];
    int code;
    code = $fscanf(fd, "%s %s %h %h %h %h %h", exp_name, exp_kind, v[0], v[1], v[2],
                   v[3], v[4]);
    if (code != 7) begin
      $display("malformed expected-result line in the trace file");
      bad_lines++;
    end
    drive_idle();
    exp_push           = 1'b1;
    exp_report.id      = id_t'(v[0]);
    exp_report.len     = len_t'(v[1]);
    exp_report.beats   = beat_cnt_t'(v[2]);
    exp_report.atop    = atop_t'(v[3]);
    exp_report.verdict = (v[4] != 0) ? VERDICT_LAST_MISMATCH : VERDICT_OK;
    exp_value          = cnt_t'(v[0]);
  endtask

  function automatic int count_lines();
    int               fd;
    int               n;
    logic [8*128-1:0] line;
    n  = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n++;
      end
      $fclose(fd);
    end
    return n;
  endfunction

  // one S or E line per cycle, comment lines take no time
  task automatic run_trace(input int fd);
    logic [63:0]      tag;
    logic [8*128-1:0] rest;
    int               code;
    code = $fscanf(fd, "%s", tag);
    while (code == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else begin
        @(negedge clk_i);
        if (tag == "S") begin
          apply_stim(fd);
        end else if (tag == "E") begin
          load_expect(fd);
        end else begin
          $display("unknown line tag %0s in the trace file", tag);
          bad_lines++;
        end
      end
      code = $fscanf(fd, "%s", tag);
    end
    @(negedge clk_i);
    drive_idle();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout, run still busy after %0d cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int fd;
    drive_idle();
    exp_name    = '0;
    exp_kind    = '0;
    exp_report  = '0;
    exp_value   = '0;
    rst_ni      = 1'b1;
    cycle_limit = 2 * count_lines() + 40;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", TRACE_FILE);
      open_err = 1'b1;
    end else begin
      run_trace(fd);
      $fclose(fd);
    end
    // wait for the checker to match every outstanding record
    @(negedge clk_i);
    while (pending != 0) begin
      @(negedge clk_i);
    end
    $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt,
             err_cnt + bad_lines);
    if (open_err || bad_lines != 0 || err_cnt != 0 || fail_cnt != 0 || pass_cnt == 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

// ==== verif/ccu_monitor_trace.txt ====
# S awvr awid awlen awatop wvr wlast bvr bid arvr arid arlen rvr rid rlast, vr is valid:ready
# E test kind a b c d e, wr/rd give id len beats atop verdict, bcount/status give value 0 0 0 0
E t1_wr_ok wr 0 3 4 00 0
S 3 0 3 00 0 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 2 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 1 0 0 0 0 0 0 0 0
E t1_wr_ok end 0 0 0 0 0
E t2_wr_last_early wr 0 3 2 00 1
S 3 0 3 00 0 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 1 0 0 0 0 0 0 0 0
E t2_wr_last_early end 0 0 0 0 0
E t3_rd_interleave rd 1 1 2 00 0
E t3_rd_interleave rd 2 2 3 00 0
S 0 0 0 00 0 0 0 0 3 1 1 0 0 0
S 0 0 0 00 0 0 0 0 3 2 2 0 0 0
S 0 0 0 00 0 0 0 0 0 0 0 3 1 0
S 0 0 0 00 0 0 0 0 0 0 0 3 2 0
S 0 0 0 00 0 0 0 0 0 0 0 3 2 0
S 0 0 0 00 0 0 0 0 0 0 0 3 1 1
S 0 0 0 00 0 0 0 0 0 0 0 3 2 1
E t3_rd_interleave end 0 0 0 0 0
E t4_atomic rd 3 2 3 21 0
E t4_atomic wr 3 4 5 21 0
E t4_atomic wr 3 1 2 20 0
E t4_atomic rd 3 1 2 20 0
S 3 3 4 21 0 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 3 3 0
S 0 0 0 00 3 0 0 0 0 0 0 3 3 0
S 0 0 0 00 3 0 0 0 0 0 0 3 3 1
S 0 0 0 00 3 1 0 0 0 0 0 0 0 0
S 3 3 1 20 0 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 0 0 0 0 0 0 0 0 0
S 0 0 0 00 3 1 0 0 0 0 0 3 3 0
S 0 0 0 00 0 0 0 0 0 0 0 3 3 1
E t4_atomic end 0 0 0 0 0
S 0 0 0 00 0 0 3 1 0 0 0 0 0 0
S 0 0 0 00 0 0 2 2 0 0 0 0 0 0
S 0 0 0 00 0 0 3 0 0 0 0 0 0 0
S 0 0 0 00 0 0 3 3 0 0 0 0 0 0
S 0 0 0 00 0 0 0 0 0 0 0 3 0 1
E t5_bcount_orphan bcount 03 0 0 0 0
E t5_bcount_orphan status 4 0 0 0 0
E t5_bcount_orphan end 0 0 0 0 0
S 0 0 0 00 0 0 0 0 3 0 0 0 0 0
S 0 0 0 00 0 0 0 0 3 0 1 0 0 0
S 0 0 0 00 0 0 0 0 3 0 0 0 0 0
S 0 0 0 00 0 0 0 0 3 0 1 0 0 0
S 0 0 0 00 0 0 0 0 3 0 2 0 0 0
E t6_fifo_drop status 6 0 0 0 0
E t6_fifo_drop rd 0 0 1 00 0
E t6_fifo_drop rd 0 1 2 00 0
E t6_fifo_drop rd 0 0 1 00 0
E t6_fifo_drop rd 0 1 2 00 0
S 0 0 0 00 0 0 0 0 0 0 0 3 0 1
S 0 0 0 00 0 0 0 0 0 0 0 3 0 0
S 0 0 0 00 0 0 0 0 0 0 0 3 0 1
S 0 0 0 00 0 0 0 0 0 0 0 3 0 1
S 0 0 0 00 0 0 0 0 0 0 0 3 0 0
S 0 0 0 00 0 0 0 0 0 0 0 3 0 1
E t6_fifo_drop end 0 0 0 0 0

// ==== src.f ====
+incdir+design
design/ccu_monitor_pkg.sv
design/burst_len_fifo.sv
design/atomic_injector.sv
design/write_tracker.sv
design/read_tracker.sv
design/ccu_monitor_top.sv
verif/ccu_monitor_checker.sv
verif/tb_ccu_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the CCU monitor testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ccu_monitor -f src.f \
  --Mdir obj_dir -o tb_ccu_monitor || exit 1
./obj_dir/tb_ccu_monitor > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
